//--- rtl/uart_defines.svh
`ifndef UART_DEFINES_SVH
`define UART_DEFINES_SVH

// frame format
`define UART_DATA_BITS  8
`define UART_OVERSAMPLE 16

// 53 gives about 115200 baud at 100 MHz with 16x oversampling
`define UART_DIV_RESET  16'd53

`define UART_ADDR_W     5

// register word offsets
`define UART_OFS_TXDATA 5'h00
`define UART_OFS_RXDATA 5'h04
`define UART_OFS_STATUS 5'h08
`define UART_OFS_CTRL   5'h0C
`define UART_OFS_DIV    5'h10

`endif

//--- rtl/uart_pkg.sv
`include "uart_defines.svh"

package uart_pkg;

	typedef enum logic [`UART_ADDR_W-1:0] {
		REG_TXDATA = `UART_OFS_TXDATA,
		REG_RXDATA = `UART_OFS_RXDATA,
		REG_STATUS = `UART_OFS_STATUS,
		REG_CTRL   = `UART_OFS_CTRL,
		REG_DIV    = `UART_OFS_DIV
	} uart_reg_e;

	typedef enum logic [1:0] {RX_IDLE, RX_DATA, RX_STOP} rx_state_e;

	typedef enum logic [1:0] {TX_IDLE, TX_START, TX_DATA, TX_STOP} tx_state_e;

	// first field is the MSB, so tx_busy lands on bit 0
	typedef struct packed {
		logic rx_overrun;
		logic rx_valid;
		logic tx_busy;
	} uart_status_t;

	typedef struct packed {
		logic tx_en; // bit 1
		logic rx_en; // bit 0
	} uart_ctrl_t;

endpackage

//--- rtl/uart_axi_pkg.sv
`include "uart_defines.svh"

package uart_axi_pkg;

	typedef enum logic [1:0] {
		RESP_OKAY   = 2'b00,
		RESP_SLVERR = 2'b10
	} axil_resp_e;

	// master to slave
	typedef struct packed {
		logic [`UART_ADDR_W-1:0] awaddr;
		logic                    awvalid;
		logic [31:0]             wdata;
		logic [3:0]              wstrb;
		logic                    wvalid;
		logic                    bready;
		logic [`UART_ADDR_W-1:0] araddr;
		logic                    arvalid;
		logic                    rready;
	} axil_req_t;

	typedef struct packed {
		logic        awready;
		logic        wready;
		axil_resp_e  bresp;
		logic        bvalid;
		logic        arready;
		logic [31:0] rdata;
		axil_resp_e  rresp;
		logic        rvalid;
	} axil_rsp_t;

endpackage

//--- rtl/uart_baud_gen.sv
module uart_baud_gen (
	input  logic        clk_i,
	input  logic        rst_i,
	input  logic [15:0] div_i,
	output logic        tick_o
);

	logic [15:0] cnt;
	logic        wrap;

	// >= so that a smaller divisor written mid-count reloads at once
	assign wrap = (cnt >= div_i);

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			cnt    <= '0;
			tick_o <= 1'b0;
		end else begin
			tick_o <= wrap; // one pulse every div_i+1 clocks
			if (wrap) begin
				cnt <= '0;
			end else begin
				cnt <= cnt + 16'd1;
			end
		end
	end

endmodule

//--- rtl/uart_rx.sv
`include "uart_defines.svh"

module uart_rx (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic                       rx_i,
	input  logic                       tick_i,
	input  logic                       rx_en_i,
	output logic [`UART_DATA_BITS-1:0] data_o,
	output logic                       done_o
);
	import uart_pkg::*;

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_BITS);

	rx_state_e                  state;
	logic [1:0]                 rx_sync;
	logic                       rx_line;
	logic [TICK_W-1:0]          tick_cnt;
	logic [BIT_W-1:0]           bit_cnt;
	logic [`UART_DATA_BITS-1:0] shreg;
	logic                       bit_end;
	logic                       half_end;

	assign rx_line  = rx_sync[1];
	assign bit_end  = tick_i && (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1));
	assign half_end = tick_i && (tick_cnt == TICK_W'(`UART_OVERSAMPLE / 2 - 1));

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			rx_sync  <= 2'b11; // line idles high
			state    <= RX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			done_o   <= 1'b0;
		end else begin
			rx_sync <= {rx_sync[0], rx_i};
			done_o  <= 1'b0;
			if (!rx_en_i) begin
				state    <= RX_IDLE;
				tick_cnt <= '0;
				bit_cnt  <= '0;
			end else if (tick_i) begin
				case (state)
					RX_IDLE: begin
						// start bit must stay low up to its middle
						if (rx_line) begin
							tick_cnt <= '0;
						end else if (half_end) begin
							state    <= RX_DATA;
							tick_cnt <= '0;
						end else begin
							tick_cnt <= tick_cnt + 1'b1;
						end
					end
					RX_DATA: begin
						tick_cnt <= tick_cnt + 1'b1; // wraps to 0 at bit_end
						if (bit_end) begin
							bit_cnt <= bit_cnt + 1'b1;
							if (&bit_cnt) begin
								state <= RX_STOP;
							end
						end
					end
					RX_STOP: begin
						tick_cnt <= tick_cnt + 1'b1;
						if (bit_end) begin
							state  <= RX_IDLE;
							done_o <= rx_line; // bad stop bit drops the frame
						end
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rx_en_i && bit_end && state == RX_DATA) begin
			shreg <= {rx_line, shreg[`UART_DATA_BITS-1:1]}; // lsb first
		end
		if (rx_en_i && bit_end && state == RX_STOP && rx_line) begin
			data_o <= shreg;
		end
	end

endmodule

//--- rtl/uart_tx.sv
`include "uart_defines.svh"

module uart_tx (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  logic                       tick_i,
	input  logic                       start_i,
	input  logic [`UART_DATA_BITS-1:0] data_i,
	output logic                       tx_o,
	output logic                       busy_o
);
	import uart_pkg::*;

	localparam int TICK_W = $clog2(`UART_OVERSAMPLE);
	localparam int BIT_W  = $clog2(`UART_DATA_BITS);

	tx_state_e                  state;
	logic [TICK_W-1:0]          tick_cnt;
	logic [BIT_W-1:0]           bit_cnt;
	logic [`UART_DATA_BITS-1:0] shreg;
	logic                       bit_end;

	assign bit_end = tick_i && (tick_cnt == TICK_W'(`UART_OVERSAMPLE - 1));
	assign busy_o  = (state != TX_IDLE);

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			state    <= TX_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			tx_o     <= 1'b1;
		end else begin
			if (state != TX_IDLE && tick_i) begin
				tick_cnt <= tick_cnt + 1'b1; // wraps at bit_end
			end
			case (state)
				TX_IDLE: begin
					tick_cnt <= '0;
					bit_cnt  <= '0;
					if (start_i) begin
						state <= TX_START;
						tx_o  <= 1'b0;
					end
				end
				TX_START: begin
					if (bit_end) begin
						state <= TX_DATA;
						tx_o  <= shreg[0];
					end
				end
				TX_DATA: begin
					if (bit_end) begin
						bit_cnt <= bit_cnt + 1'b1;
						if (&bit_cnt) begin
							state <= TX_STOP;
							tx_o  <= 1'b1;
						end else begin
							tx_o <= shreg[1]; // next bit, shreg shifts this cycle
						end
					end
				end
				TX_STOP: begin
					if (bit_end) begin
						state <= TX_IDLE;
					end
				end
				default: state <= TX_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk_i) begin
		if (state == TX_IDLE && start_i) begin
			shreg <= data_i;
		end else if (state == TX_DATA && bit_end) begin
			shreg <= shreg >> 1;
		end
	end

endmodule

//--- rtl/uart_regs.sv
`include "uart_defines.svh"

module uart_regs (
	input  logic                       clk_i,
	input  logic                       rst_i,
	input  uart_axi_pkg::axil_req_t    axil_req_i,
	input  logic [`UART_DATA_BITS-1:0] rx_data_i,
	input  logic                       rx_done_i,
	input  logic                       tx_busy_i,
	output uart_axi_pkg::axil_rsp_t    axil_rsp_o,
	output uart_pkg::uart_ctrl_t       ctrl_o,
	output logic [15:0]                div_o,
	output logic                       tx_start_o,
	output logic [`UART_DATA_BITS-1:0] tx_data_o
);
	import uart_pkg::*;
	import uart_axi_pkg::*;

	uart_ctrl_t                 ctrl_q;
	logic [15:0]                div_q;
	logic [`UART_DATA_BITS-1:0] rx_data_q;
	logic                       rx_valid_q;
	logic                       rx_overrun_q;
	logic                       bvalid_q;
	axil_resp_e                 bresp_q;
	logic                       rvalid_q;
	axil_resp_e                 rresp_q;
	logic [31:0]                rdata_q;
	logic                       wr_acc;
	logic                       rd_acc;
	logic                       tx_launch;
	logic                       rx_read;
	uart_reg_e                  wr_reg;
	uart_reg_e                  rd_reg;
	uart_status_t               status;

	// one write in flight, address and data taken together
	assign wr_acc = axil_req_i.awvalid && axil_req_i.wvalid && !bvalid_q;
	assign rd_acc = axil_req_i.arvalid && !rvalid_q;
	assign wr_reg = uart_reg_e'(axil_req_i.awaddr);
	assign rd_reg = uart_reg_e'(axil_req_i.araddr);

	assign tx_launch = wr_acc && wr_reg == REG_TXDATA && axil_req_i.wstrb[0]
		&& ctrl_q.tx_en && !tx_busy_i; // writes while busy are lost
	assign rx_read = rd_acc && rd_reg == REG_RXDATA;

	assign status.rx_overrun = rx_overrun_q;
	assign status.rx_valid   = rx_valid_q;
	assign status.tx_busy    = tx_busy_i;

	assign ctrl_o = ctrl_q;
	assign div_o  = div_q;

	always_comb begin
		axil_rsp_o         = '0;
		axil_rsp_o.awready = wr_acc;
		axil_rsp_o.wready  = wr_acc;
		axil_rsp_o.bresp   = bresp_q;
		axil_rsp_o.bvalid  = bvalid_q;
		axil_rsp_o.arready = !rvalid_q;
		axil_rsp_o.rdata   = rdata_q;
		axil_rsp_o.rresp   = rresp_q;
		axil_rsp_o.rvalid  = rvalid_q;
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			bvalid_q   <= 1'b0;
			bresp_q    <= RESP_OKAY;
			ctrl_q     <= '0;
			div_q      <= `UART_DIV_RESET;
			tx_start_o <= 1'b0;
		end else begin
			tx_start_o <= tx_launch;
			if (bvalid_q && axil_req_i.bready) begin
				bvalid_q <= 1'b0;
			end
			if (wr_acc) begin
				bvalid_q <= 1'b1;
				bresp_q  <= RESP_OKAY;
				case (wr_reg)
					REG_TXDATA, REG_RXDATA, REG_STATUS: ; // no stored state here
					REG_CTRL: if (axil_req_i.wstrb[0]) ctrl_q <= uart_ctrl_t'(axil_req_i.wdata[1:0]);
					REG_DIV: begin
						if (axil_req_i.wstrb[0]) div_q[7:0] <= axil_req_i.wdata[7:0];
						if (axil_req_i.wstrb[1]) div_q[15:8] <= axil_req_i.wdata[15:8];
					end
					default: bresp_q <= RESP_SLVERR;
				endcase
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (!rst_i) begin
			rvalid_q     <= 1'b0;
			rx_valid_q   <= 1'b0;
			rx_overrun_q <= 1'b0;
		end else begin
			if (rvalid_q && axil_req_i.rready) begin
				rvalid_q <= 1'b0;
			end
			if (rd_acc) begin
				rvalid_q <= 1'b1;
			end
			if (rx_read) begin
				rx_valid_q   <= 1'b0;
				rx_overrun_q <= 1'b0;
			end
			// a byte arriving with the read is the new one, not an overrun
			if (rx_done_i) begin
				rx_valid_q <= 1'b1;
				if (rx_valid_q && !rx_read) begin
					rx_overrun_q <= 1'b1;
				end
			end
		end
	end

	always_ff @(posedge clk_i) begin
		if (rd_acc) begin
			rresp_q <= RESP_OKAY;
			rdata_q <= '0;
			case (rd_reg)
				REG_TXDATA: ; // write only, reads zero
				REG_RXDATA: rdata_q <= 32'(rx_data_q);
				REG_STATUS: rdata_q <= 32'(status);
				REG_CTRL:   rdata_q <= 32'(ctrl_q);
				REG_DIV:    rdata_q <= 32'(div_q);
				default:    rresp_q <= RESP_SLVERR;
			endcase
		end
		if (rx_done_i) begin
			rx_data_q <= rx_data_i;
		end
		if (tx_launch) begin
			tx_data_o <= axil_req_i.wdata[`UART_DATA_BITS-1:0];
		end
	end

endmodule

//--- rtl/uart_top.sv
`include "uart_defines.svh"

module uart_top (
	input  logic                    clk_i,
	input  logic                    rst_i,
	input  uart_axi_pkg::axil_req_t axil_req_i,
	input  logic                    rx_i,
	output uart_axi_pkg::axil_rsp_t axil_rsp_o,
	output logic                    tx_o
);
	import uart_pkg::*;

	uart_ctrl_t                 ctrl;
	logic [15:0]                div;
	logic                       tick;
	logic [`UART_DATA_BITS-1:0] rx_data;
	logic                       rx_done;
	logic                       tx_start;
	logic [`UART_DATA_BITS-1:0] tx_data;
	logic                       tx_busy;

	uart_regs u_uart_regs (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.axil_req_i (axil_req_i),
		.rx_data_i  (rx_data),
		.rx_done_i  (rx_done),
		.tx_busy_i  (tx_busy),
		.axil_rsp_o (axil_rsp_o),
		.ctrl_o     (ctrl),
		.div_o      (div),
		.tx_start_o (tx_start),
		.tx_data_o  (tx_data)
	);

	uart_baud_gen u_uart_baud_gen (
		.clk_i  (clk_i),
		.rst_i  (rst_i),
		.div_i  (div),
		.tick_o (tick)
	);

	// tx_en only gates the launch inside the register block
	uart_rx u_uart_rx (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.rx_i    (rx_i),
		.tick_i  (tick),
		.rx_en_i (ctrl.rx_en),
		.data_o  (rx_data),
		.done_o  (rx_done)
	);

	uart_tx u_uart_tx (
		.clk_i   (clk_i),
		.rst_i   (rst_i),
		.tick_i  (tick),
		.start_i (tx_start),
		.data_i  (tx_data),
		.tx_o    (tx_o),
		.busy_o  (tx_busy)
	);

endmodule

//--- tb/uart_tb.sv
`include "uart_defines.svh"

module uart_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import uart_pkg::*;
	import uart_axi_pkg::*;

	logic      clk_i;
	logic      rst_i;
	logic      rx_i;
	logic      tx_o;
	axil_req_t axil_req;
	axil_rsp_t axil_rsp;
	integer    seed;
	int        cur_div; // divisor last written, sets the serial bit time

	uart_top u_uart_top (
		.clk_i      (clk_i),
		.rst_i      (rst_i),
		.axil_req_i (axil_req),
		.rx_i       (rx_i),
		.axil_rsp_o (axil_rsp),
		.tx_o       (tx_o)
	);

	always #50 clk_i = ~clk_i;

	task automatic stop_run(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1);
	endtask

	task automatic check_data(input string name, input logic [31:0] exp, input logic [31:0] act);
		if (act !== exp) begin
			$display("FAILED %s: expected %h, actual %h", name, exp, act);
			stop_run("read data mismatch");
		end
	endtask

	task automatic check_resp(input string name, input axil_resp_e exp, input axil_resp_e act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			stop_run("bus response mismatch");
		end
	endtask

	task automatic check_status(input string name, input uart_status_t exp,
		input uart_status_t act);
		if (act !== exp) begin
			$display("FAILED %s: expected %b, actual %b", name, exp, act);
			stop_run("status mismatch");
		end
	endtask

	function automatic uart_status_t make_status(input bit overrun, input bit valid,
		input bit busy);
		uart_status_t s;
		s.rx_overrun = overrun;
		s.rx_valid   = valid;
		s.tx_busy    = busy;
		return s;
	endfunction

	task automatic axil_write(input logic [`UART_ADDR_W-1:0] addr, input logic [31:0] data,
		output axil_resp_e resp);
		int cnt;
		cnt = 0;
		@(negedge clk_i);
		axil_req.awaddr  = addr;
		axil_req.awvalid = 1'b1;
		axil_req.wdata   = data;
		axil_req.wstrb   = 4'hf;
		axil_req.wvalid  = 1'b1;
		do begin
			@(negedge clk_i);
			cnt++;
			if (cnt > 100) stop_run("write response never arrived");
		end while (axil_rsp.bvalid !== 1'b1);
		resp             = axil_rsp.bresp;
		axil_req.awvalid = 1'b0;
		axil_req.wvalid  = 1'b0;
		axil_req.bready  = 1'b1;
		@(negedge clk_i);
		axil_req.bready  = 1'b0;
	endtask

	task automatic axil_read(input logic [`UART_ADDR_W-1:0] addr, output logic [31:0] data,
		output axil_resp_e resp);
		int cnt;
		cnt = 0;
		@(negedge clk_i);
		axil_req.araddr  = addr;
		axil_req.arvalid = 1'b1;
		do begin
			@(negedge clk_i);
			cnt++;
			if (cnt > 100) stop_run("read response never arrived");
		end while (axil_rsp.rvalid !== 1'b1);
		data             = axil_rsp.rdata;
		resp             = axil_rsp.rresp;
		axil_req.arvalid = 1'b0;
		axil_req.rready  = 1'b1;
		@(negedge clk_i);
		axil_req.rready  = 1'b0;
	endtask

	task automatic serial_send(input logic [7:0] data, input logic stop_bit);
		int bit_clocks;
		bit_clocks = (cur_div + 1) * 16;
		@(negedge clk_i);
		rx_i = 1'b0; // start bit
		repeat (bit_clocks) @(negedge clk_i);
		for (int i = 0; i < 8; i++) begin
			rx_i = data[i];
			repeat (bit_clocks) @(negedge clk_i);
		end
		rx_i = stop_bit;
		// a bad stop is cut short so the idle line after it cannot pass for a start bit
		repeat (stop_bit ? bit_clocks : bit_clocks * 3 / 4) @(negedge clk_i);
		rx_i = 1'b1;
	endtask

	task automatic serial_receive(output logic [7:0] data);
		int bit_clocks;
		int cnt;
		bit_clocks = (cur_div + 1) * 16;
		cnt = 0;
		while (tx_o !== 1'b0) begin
			@(negedge clk_i);
			cnt++;
			if (cnt > 20 * bit_clocks) stop_run("no start bit seen on tx_o");
		end
		repeat (bit_clocks / 2) @(negedge clk_i); // to the middle of the start bit
		if (tx_o !== 1'b0) stop_run("start bit on tx_o is too short");
		for (int i = 0; i < 8; i++) begin
			repeat (bit_clocks) @(negedge clk_i);
			data[i] = tx_o;
		end
		repeat (bit_clocks) @(negedge clk_i);
		if (tx_o !== 1'b1) stop_run("stop bit on tx_o is low");
	endtask

	task automatic poll_status(input string name, input uart_status_t want);
		logic [31:0] d;
		axil_resp_e  r;
		int          cnt;
		cnt = 0;
		axil_read(REG_STATUS, d, r);
		while (d[2:0] !== want && cnt < 2000) begin
			cnt++;
			axil_read(REG_STATUS, d, r);
		end
		// a mismatch here means the wait timed out
		check_status(name, want, uart_status_t'(d[2:0]));
	endtask

	task automatic reset_values();
		logic [31:0] d;
		axil_resp_e  r;
		axil_read(REG_STATUS, d, r);
		check_resp("reset_values status resp", RESP_OKAY, r);
		check_status("reset_values status", make_status(0, 0, 0), uart_status_t'(d[2:0]));
		axil_read(REG_CTRL, d, r);
		check_data("reset_values ctrl", 32'd0, d);
		axil_read(REG_DIV, d, r);
		check_data("reset_values div", 32'd53, d);
		check_data("reset_values tx_o", 32'd1, {31'd0, tx_o});
	endtask

	task automatic transmit_byte();
		logic [7:0]  b;
		logic [7:0]  got;
		logic [31:0] d;
		axil_resp_e  r;
		b = $random(seed);
		axil_write(REG_DIV, 32'd3, r);
		cur_div = 3;
		axil_write(REG_CTRL, 32'h2, r); // tx_en
		fork
			serial_receive(got);
			begin
				axil_write(REG_TXDATA, {24'd0, b}, r);
				axil_read(REG_STATUS, d, r);
				check_status("transmit busy", make_status(0, 0, 1), uart_status_t'(d[2:0]));
			end
		join
		check_data("transmit byte", {24'd0, b}, {24'd0, got});
		poll_status("transmit idle", make_status(0, 0, 0));
	endtask

	task automatic receive_byte();
		logic [7:0]  b;
		logic [31:0] d;
		axil_resp_e  r;
		b = $random(seed);
		axil_write(REG_CTRL, 32'h3, r);
		serial_send(b, 1'b1);
		poll_status("receive valid", make_status(0, 1, 0));
		axil_read(REG_RXDATA, d, r);
		check_data("receive byte", {24'd0, b}, d);
		axil_read(REG_STATUS, d, r);
		check_status("receive cleared", make_status(0, 0, 0), uart_status_t'(d[2:0]));
	endtask

	task automatic overrun_flags();
		logic [7:0]  b1;
		logic [7:0]  b2;
		logic [31:0] d;
		axil_resp_e  r;
		b1 = $random(seed);
		b2 = $random(seed);
		serial_send(b1, 1'b1);
		serial_send(b2, 1'b1);
		poll_status("overrun flags", make_status(1, 1, 0));
		axil_read(REG_RXDATA, d, r);
		check_data("overrun byte", {24'd0, b2}, d);
		axil_read(REG_STATUS, d, r);
		check_status("overrun cleared", make_status(0, 0, 0), uart_status_t'(d[2:0]));
	endtask

	task automatic disable_and_framing();
		logic [31:0] d;
		axil_resp_e  r;
		axil_write(REG_CTRL, 32'h2, r); // receiver off
		serial_send($random(seed), 1'b1);
		axil_read(REG_STATUS, d, r);
		check_status("rx disabled", make_status(0, 0, 0), uart_status_t'(d[2:0]));
		axil_write(REG_CTRL, 32'h3, r);
		serial_send($random(seed), 1'b0);
		repeat ((cur_div + 1) * 32) @(negedge clk_i); // room for a wrong rx_done
		axil_read(REG_STATUS, d, r);
		check_status("bad stop bit", make_status(0, 0, 0), uart_status_t'(d[2:0]));
	endtask

	task automatic bus_errors();
		logic [7:0]  b1;
		logic [7:0]  b2;
		logic [7:0]  got;
		logic [31:0] d;
		axil_resp_e  r;
		axil_read(5'h14, d, r);
		check_resp("unmapped read resp", RESP_SLVERR, r);
		check_data("unmapped read data", 32'd0, d);
		axil_write(5'h14, 32'hffff_ffff, r);
		check_resp("unmapped write resp", RESP_SLVERR, r);
		b1 = $random(seed);
		b2 = ~b1;
		fork
			serial_receive(got);
			begin
				axil_write(REG_TXDATA, {24'd0, b1}, r);
				axil_write(REG_TXDATA, {24'd0, b2}, r); // transmitter is busy here
			end
		join
		check_data("busy write first byte", {24'd0, b1}, {24'd0, got});
		repeat ((cur_div + 1) * 16 * 20) begin
			@(negedge clk_i);
			if (tx_o !== 1'b1) stop_run("a TXDATA write made while busy was sent");
		end
	endtask

	initial begin
		seed     = 60399;
		cur_div  = 53;
		clk_i    = 1'b0;
		rst_i    = 1'b0;
		rx_i     = 1'b1;
		axil_req = '0;
		repeat (4) @(negedge clk_i);
		rst_i = 1'b1;
		reset_values();
		transmit_byte();
		receive_byte();
		overrun_flags();
		disable_and_framing();
		bus_errors();
		$display(">>> PASS");
		$finish;
	end

endmodule

//--- sources.f
+incdir+rtl
rtl/uart_pkg.sv
rtl/uart_axi_pkg.sv
rtl/uart_baud_gen.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/uart_regs.sv
rtl/uart_top.sv
tb/uart_tb.sv

//--- Bender.yml
package:
  name: uart

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/uart_pkg.sv
      - rtl/uart_axi_pkg.sv
      - rtl/uart_baud_gen.sv
      - rtl/uart_rx.sv
      - rtl/uart_tx.sv
      - rtl/uart_regs.sv
      - rtl/uart_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - tb/uart_tb.sv
